/* Bender.yml */
package:
  name: itof_unit

sources:
  - logic/itof_pkg.sv
  - logic/itof_stage_if.sv
  - logic/itof_rs.sv
  - logic/itof_normalize.sv
  - logic/itof_round.sv
  - logic/itof_unit.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/itof_tb.sv

/* dv/itof_cases.svh */
`ifndef ITOF_CASES_SVH
`define ITOF_CASES_SVH

// One directed conversion. delay counts cycles from issue to the CDB broadcast.
typedef struct packed {
	itof_op_e op;
	logic [31:0] opd;
	logic by_cdb;
	logic [1:0] delay;
	logic [31:0] expected;
} case_t;

case_t cases [$];

task automatic add_case(input itof_op_e op, input logic [31:0] opd, input logic by_cdb,
		input logic [1:0] delay, input logic [31:0] expected);
	case_t c;
	c.op = op;
	c.opd = opd;
	c.by_cdb = by_cdb;
	c.delay = delay;
	c.expected = expected;
	cases.push_back(c);
endtask

task automatic load_cases();
	// Exact values.
	add_case(op_cvt_s_w, 32'h0000_0000, 1'b0, 2'd0, 32'h0000_0000);
	add_case(op_cvt_s_w, 32'h0000_0001, 1'b0, 2'd0, 32'h3f80_0000);
	add_case(op_cvt_s_w, 32'hffff_ffff, 1'b0, 2'd0, 32'hbf80_0000);
	add_case(op_cvt_s_w, 32'h0000_0002, 1'b0, 2'd0, 32'h4000_0000);
	add_case(op_cvt_s_w, 32'h0001_0000, 1'b0, 2'd0, 32'h4780_0000);
	add_case(op_cvt_s_w, 32'h4000_0000, 1'b0, 2'd0, 32'h4e80_0000);
	add_case(op_cvt_s_w, 32'h8000_0000, 1'b0, 2'd0, 32'hcf00_0000);
	add_case(op_cvt_s_w, 32'hffff_fff6, 1'b0, 2'd0, 32'hc120_0000);
	// Rounding, ties go to the even mantissa.
	add_case(op_cvt_s_w, 32'h0100_0001, 1'b0, 2'd0, 32'h4b80_0000);
	add_case(op_cvt_s_w, 32'h0100_0003, 1'b0, 2'd0, 32'h4b80_0002);
	add_case(op_cvt_s_w, 32'h0100_0005, 1'b0, 2'd0, 32'h4b80_0002);
	add_case(op_cvt_s_w, 32'h0200_0003, 1'b0, 2'd0, 32'h4c00_0001);
	add_case(op_cvt_s_w, 32'hfeff_fffd, 1'b0, 2'd0, 32'hcb80_0002);
	add_case(op_cvt_s_w, 32'h7fff_ffff, 1'b0, 2'd0, 32'h4f00_0000);
	// Unsigned word, top bit is magnitude.
	add_case(op_cvt_s_wu, 32'h8000_0000, 1'b0, 2'd0, 32'h4f00_0000);
	add_case(op_cvt_s_wu, 32'hffff_ffff, 1'b0, 2'd0, 32'h4f80_0000);
	add_case(op_cvt_s_wu, 32'hffff_ff80, 1'b0, 2'd0, 32'h4f80_0000);
	add_case(op_cvt_s_wu, 32'hffff_ff7f, 1'b0, 2'd0, 32'h4f7f_ffff);
	// Late operand, then a ready one behind it that overtakes.
	add_case(op_cvt_s_wu, 32'h0000_0003, 1'b1, 2'd3, 32'h4040_0000);
	add_case(op_cvt_s_w, 32'hfeff_ffff, 1'b0, 2'd0, 32'hcb80_0000);
	add_case(op_cvt_s_wu, 32'h0000_0001, 1'b1, 2'd0, 32'h3f80_0000);
	add_case(op_cvt_s_w, 32'h0000_0002, 1'b1, 2'd1, 32'h4000_0000);
endtask

`endif

/* dv/itof_tb.sv */
`timescale 1ns/10ps

module itof_tb
	import itof_pkg::*;
();
	logic clk;
	logic reset;
	logic issue_valid;
	logic issue_ready;
	rob_tag_t issue_tag;
	itof_op_e issue_op;
	cdb_t gpr_read;
	cdb_t gpr_cdb;
	logic result_valid;
	logic result_ready;
	rob_tag_t result_tag;
	logic [31:0] result_data;

	// Scoreboard indexed by destination tag.
	logic pending [1<<rob_width];
	logic [31:0] exp_data [1<<rob_width];
	// Position of each tag's result in the output stream.
	int arrival [1<<rob_width];
	int arrivals;
	int wake_due [$];
	rob_tag_t wake_tag [$];
	logic [31:0] wake_data [$];
	int stretch_len [64];
	int cycle = 0;
	rob_tag_t next_tag;
	logic stall_mode;
	logic saw_full;
	int value_errors;
	int other_errors;
	int checked;

	`include "itof_cases.svh"

	itof_unit i_dut (
		.clk (clk),
		.reset (reset),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.issue_tag (issue_tag),
		.issue_op (issue_op),
		.gpr_read (gpr_read),
		.gpr_cdb (gpr_cdb),
		.result_valid (result_valid),
		.result_ready (result_ready),
		.result_tag (result_tag),
		.result_data (result_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	////////////////////
	// Reference model.
	////////////////////

	// Nearest even, by comparing the dropped bits with one half.
	function automatic logic [31:0] ref_cvt(input itof_op_e op, input logic [31:0] v);
		logic neg;
		logic [31:0] m;
		logic [31:0] kept;
		logic [31:0] rem;
		logic [31:0] half;
		int top;
		int sh;
		neg = (op == op_cvt_s_w) && v[31];
		m = neg ? (~v + 32'd1) : v;
		if (m == 32'd0) begin
			return 32'd0;
		end
		top = 31;
		while (!m[top]) begin
			top--;
		end
		sh = top - 23;
		if (sh <= 0) begin
			kept = m << (-sh);
		end else begin
			kept = m >> sh;
			rem = m & ((32'd1 << sh) - 32'd1);
			half = 32'd1 << (sh - 1);
			if (rem > half || (rem == half && kept[0])) begin
				kept = kept + 32'd1;
			end
			if (kept[24]) begin
				kept = kept >> 1;
				top = top + 1;
			end
		end
		return {neg, 8'(top + 127), kept[22:0]};
	endfunction

	task automatic finish_run();
		$display("Errors: %0d wrong values, %0d other; %0d results checked",
			value_errors, other_errors, checked);
		if (value_errors == 0 && other_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	endtask

	task automatic abort_on_timeout(input string what);
		other_errors++;
		$display("Timeout at %0t: %s", $time, what);
		finish_run();
	endtask

	////////////////////
	// Stimulus.
	////////////////////

	// A due wakeup goes first, else the issuing instruction's own broadcast.
	task automatic drive_cdb(input logic own, input rob_tag_t own_tag,
			input logic [31:0] own_data, output logic sent);
		int idx;
		idx = -1;
		sent = 1'b0;
		for (int i = wake_due.size() - 1; i >= 0; i--) begin
			if (wake_due[i] <= cycle) begin
				idx = i;
			end
		end
		if (idx >= 0) begin
			gpr_cdb = '{1'b1, wake_tag[idx], wake_data[idx]};
			wake_due.delete(idx);
			wake_tag.delete(idx);
			wake_data.delete(idx);
		end else if (own) begin
			gpr_cdb = '{1'b1, own_tag, own_data};
			sent = 1'b1;
		end else begin
			gpr_cdb = '0;
		end
	endtask

	// The producer tag is the destination tag with its top bit flipped.
	task automatic issue_one(input itof_op_e op, input logic [31:0] opd, input logic by_cdb,
			input int delay, input logic [31:0] expected);
		rob_tag_t src;
		logic sent;
		logic accepted;
		int waited;
		src = next_tag ^ 5'h10;
		accepted = 1'b0;
		waited = 0;
		while (!accepted && waited < 200) begin
			@(negedge clk);
			drive_cdb(by_cdb && delay == 0, src, opd, sent);
			issue_valid = 1'b1;
			issue_tag = next_tag;
			issue_op = op;
			gpr_read = '{!by_cdb, src, by_cdb ? 32'd0 : opd};
			@(posedge clk);
			accepted = issue_ready;
			saw_full = saw_full || !issue_ready;
			waited++;
		end
		if (!accepted) begin
			abort_on_timeout("issue_ready stayed low");
		end
		pending[next_tag] = 1'b1;
		exp_data[next_tag] = expected;
		if (by_cdb && !sent) begin
			wake_due.push_back(cycle + delay);
			wake_tag.push_back(src);
			wake_data.push_back(opd);
		end
		next_tag = next_tag + 1'b1;
	endtask

	task automatic drain();
		logic sent;
		int waited;
		waited = 0;
		while ((pending.sum() with (int'(item)) > 0 || wake_due.size() > 0) && waited < 500) begin
			@(negedge clk);
			issue_valid = 1'b0;
			drive_cdb(1'b0, '0, '0, sent);
			waited++;
		end
		if (waited >= 500) begin
			abort_on_timeout("results still outstanding");
		end
	endtask

	////////////////////
	// Result side.
	////////////////////

	initial begin
		int k;
		int hold;
		k = 0;
		hold = 0;
		result_ready = 1'b1;
		forever begin
			@(negedge clk);
			if (!stall_mode) begin
				result_ready = 1'b1;
			end else if (hold > 0) begin
				hold--;
			end else begin
				result_ready = !result_ready;
				hold = result_ready ? stretch_len[k] / 4 : stretch_len[k];
				k = (k + 1) % 64;
			end
		end
	end

	always @(posedge clk) begin
		if (!reset && result_valid && result_ready) begin
			if (!pending[result_tag]) begin
				other_errors++;
				$display("Result for tag %0d at %0t had no instruction outstanding",
					result_tag, $time);
			end else if (result_data !== exp_data[result_tag]) begin
				value_errors++;
				$display("[FAIL] %0t: tag %0d gave %h, expected %h", $time, result_tag,
					result_data, exp_data[result_tag]);
			end
			pending[result_tag] = 1'b0;
			arrival[result_tag] = arrivals;
			arrivals++;
			checked++;
		end
	end

	initial begin
		logic [31:0] v;
		itof_op_e op;
		void'($urandom(32'hce73));
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_tag = '0;
		issue_op = op_cvt_s_w;
		gpr_read = '0;
		gpr_cdb = '0;
		stall_mode = 1'b0;
		saw_full = 1'b0;
		next_tag = '0;
		value_errors = 0;
		other_errors = 0;
		checked = 0;
		arrivals = 0;
		foreach (pending[i]) begin
			pending[i] = 1'b0;
		end
		foreach (stretch_len[i]) begin
			stretch_len[i] = 1 + $urandom % 16;
		end
		load_cases();
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		if (result_valid !== 1'b0 || issue_ready !== 1'b1) begin
			value_errors++;
			$display("[FAIL] %0t: after reset result_valid=%b issue_ready=%b", $time,
				result_valid, issue_ready);
		end
		foreach (cases[i]) begin
			issue_one(cases[i].op, cases[i].opd, cases[i].by_cdb, cases[i].delay,
				cases[i].expected);
		end
		drain();
		// Directed tags equal the case index.
		// A ready case issued right behind a late operand comes out first.
		for (int i = 0; i + 1 < cases.size(); i++) begin
			if (cases[i].by_cdb && cases[i].delay >= 2'd2 && !cases[i+1].by_cdb &&
					arrival[i+1] > arrival[i]) begin
				other_errors++;
				$display("Tag %0d was not overtaken by the ready tag %0d issued behind it",
					i, i + 1);
			end
		end
		// Random operands while the arbiter stalls.
		stall_mode = 1'b1;
		saw_full = 1'b0;
		repeat (40) begin
			v = $urandom;
			op = itof_op_e'($urandom % 2);
			issue_one(op, v, 1'(($urandom % 2)), $urandom % 4, ref_cvt(op, v));
		end
		drain();
		if (!saw_full) begin
			other_errors++;
			$display("issue_ready never fell while the result side was stalled");
		end
		finish_run();
	end
endmodule

/* logic/itof_normalize.sv */
`timescale 1ns/10ps

module itof_normalize
	import itof_pkg::*;
(
	input logic clk,
	input logic reset,
	itof_dispatch_if.dst in,
	itof_norm_if.src out
);
	logic sign;
	logic [31:0] mag;
	logic [5:0] lzc;
	logic [31:0] aligned;
	logic [7:0] exp;
	logic accept;

	// Stage takes a new item when empty or when its output leaves this cycle.
	assign in.ready = !out.valid || out.ready;
	assign accept = in.valid && in.ready;

	////////////////////
	// Magnitude.
	////////////////////

	assign sign = (in.op == op_cvt_s_w) && in.data[31];

	// Most negative word negates to itself, which is the right magnitude.
	assign mag = sign ? -in.data : in.data;

	////////////////////
	// Leading zeros.
	////////////////////

	always_comb begin
		lzc = 6'd32;
		for (int i = 0; i < 32; i++) begin
			if (mag[i]) begin
				lzc = 6'(31 - i);
			end
		end
	end

	// Leading one lands in bit 31.
	assign aligned = mag << lzc;

	// Zero keeps exponent 0, which packs as +0.0.
	always_comb begin
		if (lzc == 6'd32) begin
			exp = 8'd0;
		end else begin
			exp = 8'(exp_bias + 31 - int'(lzc));
		end
	end

	////////////////////
	// Output register.
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			out.valid <= 1'b0;
		end else if (in.ready) begin
			out.valid <= in.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out.tag <= in.tag;
			out.sign <= sign;
			out.exp <= exp;
			out.mant <= aligned[31:8];
			out.guard <= aligned[7];
			out.sticky <= |aligned[6:0];
		end
	end
endmodule

/* logic/itof_pkg.sv */
package itof_pkg;

	////////////////////
	// Widths and sizes.
	////////////////////

	localparam int rob_width = 5;
	localparam int rs_depth = 2;
	localparam int rs_idx_width = $clog2(rs_depth);

	// IEEE-754 single precision exponent bias.
	localparam int exp_bias = 127;

	typedef logic [rob_width-1:0] rob_tag_t;
	typedef logic [rs_idx_width-1:0] rs_idx_t;

	////////////////////
	// Bus and entry types.
	////////////////////

	// GPR read port and GPR CDB broadcast share this shape.
	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		logic [31:0] data;
	} cdb_t;

	typedef enum logic [0:0] {
		op_cvt_s_w = 1'b0,
		op_cvt_s_wu = 1'b1
	} itof_op_e;

	// One reservation station slot. tag is the destination ROB slot,
	// opd.tag the producer of the source operand.
	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		itof_op_e op;
		cdb_t opd;
	} rs_entry_t;

endpackage

/* logic/itof_round.sv */
`timescale 1ns/10ps

module itof_round
	import itof_pkg::*;
(
	input logic clk,
	input logic reset,
	itof_norm_if.dst in,
	output logic result_valid,
	input logic result_ready,
	output rob_tag_t result_tag,
	output logic [31:0] result_data
);
	logic round_up;
	logic [24:0] sum;
	logic [22:0] frac;
	logic [7:0] exp;
	logic accept;

	assign in.ready = !result_valid || result_ready;
	assign accept = in.valid && in.ready;

	////////////////////
	// Round to nearest even.
	////////////////////

	// Above half, or exactly half with an odd last bit.
	assign round_up = in.guard && (in.sticky || in.mant[0]);
	assign sum = {1'b0, in.mant} + 25'(round_up);

	// Carry out leaves 1.000..., so the fraction drops to zero.
	always_comb begin
		if (sum[24]) begin
			frac = sum[23:1];
			exp = in.exp + 8'd1;
		end else begin
			frac = sum[22:0];
			exp = in.exp;
		end
	end

	////////////////////
	// Result register.
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else if (in.ready) begin
			result_valid <= in.valid;
		end
	end

	// Held while the arbiter keeps ready low.
	always_ff @(posedge clk) begin
		if (accept) begin
			result_tag <= in.tag;
			result_data <= {in.sign, exp, frac};
		end
	end
endmodule

/* logic/itof_rs.sv */
`timescale 1ns/10ps

module itof_rs
	import itof_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic issue_valid,
	output logic issue_ready,
	input rob_tag_t issue_tag,
	input itof_op_e issue_op,
	input cdb_t gpr_read,
	input cdb_t gpr_cdb,
	itof_dispatch_if.src dispatch
);
	// Filled from index 0, so a lower index is always older.
	rs_entry_t e [rs_depth];
	rs_entry_t e_upd [rs_depth+1];
	rs_entry_t e_shift [rs_depth];
	rs_entry_t e_next [rs_depth];
	rs_entry_t e_new;
	logic [rs_depth-1:0] rdy;
	rs_idx_t sel;
	rs_idx_t lock_idx;
	logic locked;
	logic issue_fire;
	logic xfer;

	function automatic logic tag_hit(input cdb_t bus, input rob_tag_t tag);
		return bus.valid && (bus.tag == tag);
	endfunction

	////////////////////
	// Capture and wakeup.
	////////////////////

	// Operand comes from the read port, or from a CDB hit in the issue cycle.
	always_comb begin
		e_new.valid = 1'b1;
		e_new.tag = issue_tag;
		e_new.op = issue_op;
		e_new.opd.tag = gpr_read.tag;
		if (gpr_read.valid) begin
			e_new.opd.valid = 1'b1;
			e_new.opd.data = gpr_read.data;
		end else begin
			e_new.opd.valid = tag_hit(gpr_cdb, gpr_read.tag);
			e_new.opd.data = gpr_cdb.data;
		end
	end

	always_comb begin
		for (int i = 0; i < rs_depth; i++) begin
			e_upd[i] = e[i];
			if (!e[i].opd.valid && tag_hit(gpr_cdb, e[i].opd.tag)) begin
				e_upd[i].opd.valid = 1'b1;
				e_upd[i].opd.data = gpr_cdb.data;
			end
		end
		// Empty slot shifted in at the top on compaction.
		e_upd[rs_depth] = '0;
	end

	////////////////////
	// Dispatch select.
	////////////////////

	// Oldest ready entry wins, but a stalled choice is held until it transfers.
	always_comb begin
		for (int i = 0; i < rs_depth; i++) begin
			rdy[i] = e[i].valid && e[i].opd.valid;
		end
		sel = '0;
		for (int i = rs_depth - 1; i >= 0; i--) begin
			if (rdy[i]) begin
				sel = rs_idx_t'(i);
			end
		end
		if (locked) begin
			sel = lock_idx;
		end
	end

	assign dispatch.valid = |rdy;
	assign dispatch.tag = e[sel].tag;
	assign dispatch.op = e[sel].op;
	assign dispatch.data = e[sel].opd.data;

	assign xfer = dispatch.valid && dispatch.ready;
	assign issue_ready = !e[rs_depth-1].valid || xfer;
	assign issue_fire = issue_valid && issue_ready;

	////////////////////
	// Compact and insert.
	////////////////////

	always_comb begin
		logic placed;
		placed = 1'b0;
		for (int i = 0; i < rs_depth; i++) begin
			if (xfer && (i >= sel)) begin
				e_shift[i] = e_upd[i+1];
			end else begin
				e_shift[i] = e_upd[i];
			end
		end
		for (int i = 0; i < rs_depth; i++) begin
			e_next[i] = e_shift[i];
			if (issue_fire && !placed && !e_shift[i].valid) begin
				e_next[i] = e_new;
				placed = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < rs_depth; i++) begin
				e[i].valid <= 1'b0;
				e[i].opd.valid <= 1'b0;
			end
			locked <= 1'b0;
		end else begin
			e <= e_next;
			locked <= dispatch.valid && !dispatch.ready;
		end
	end

	always_ff @(posedge clk) begin
		lock_idx <= sel;
	end
endmodule

/* logic/itof_stage_if.sv */
`timescale 1ns/10ps

// Station to normalize stage.
interface itof_dispatch_if
	import itof_pkg::*;
();
	logic valid;
	logic ready;
	rob_tag_t tag;
	itof_op_e op;
	logic [31:0] data;

	modport src (output valid, tag, op, data, input ready);
	modport dst (input valid, tag, op, data, output ready);
endinterface

// Normalize stage to round stage.
interface itof_norm_if
	import itof_pkg::*;
();
	logic valid;
	logic ready;
	rob_tag_t tag;
	logic sign;
	logic [7:0] exp;
	logic [23:0] mant;
	logic guard;
	logic sticky;

	modport src (output valid, tag, sign, exp, mant, guard, sticky, input ready);
	modport dst (input valid, tag, sign, exp, mant, guard, sticky, output ready);
endinterface

/* logic/itof_unit.sv */
`timescale 1ns/10ps

module itof_unit
	import itof_pkg::*;
(
	input logic clk,
	input logic reset,

	// Issue side.
	input logic issue_valid,
	output logic issue_ready,
	input rob_tag_t issue_tag,
	input itof_op_e issue_op,
	input cdb_t gpr_read,

	// Wakeup.
	input cdb_t gpr_cdb,

	// Result side, toward the FPR CDB arbiter.
	output logic result_valid,
	input logic result_ready,
	output rob_tag_t result_tag,
	output logic [31:0] result_data
);
	itof_dispatch_if dispatch_if ();
	itof_norm_if norm_if ();

	////////////////////
	// Stages.
	////////////////////

	itof_rs i_rs (
		.clk (clk),
		.reset (reset),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.issue_tag (issue_tag),
		.issue_op (issue_op),
		.gpr_read (gpr_read),
		.gpr_cdb (gpr_cdb),
		.dispatch (dispatch_if.src)
	);

	itof_normalize i_normalize (
		.clk (clk),
		.reset (reset),
		.in (dispatch_if.dst),
		.out (norm_if.src)
	);

	itof_round i_round (
		.clk (clk),
		.reset (reset),
		.in (norm_if.dst),
		.result_valid (result_valid),
		.result_ready (result_ready),
		.result_tag (result_tag),
		.result_data (result_data)
	);
endmodule

/* sources.f */
+incdir+dv
logic/itof_pkg.sv
logic/itof_stage_if.sv
logic/itof_rs.sv
logic/itof_normalize.sv
logic/itof_round.sv
logic/itof_unit.sv
dv/itof_tb.sv
